// ==== src/icmp_pkg.sv ====
/*
 * ICMP transmit shared definitions
 * Sequencer states, ICMP type codes, station addresses and frame sizes
 */
`default_nettype none

package icmp_pkg;

  // ------------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------------
  typedef enum logic [7:0] {
    st_idle     = 8'b0000_0001,  // Waiting for a command
    st_build    = 8'b0000_0010,  // Header checksums in progress
    st_preamble = 8'b0000_0100,
    st_header   = 8'b0000_1000,  // Ethernet + IP + ICMP headers
    st_payload  = 8'b0001_0000,
    st_pad      = 8'b0010_0000,  // Zero fill up to minimum payload
    st_fcs      = 8'b0100_0000
  } tx_state_t;

  typedef enum logic [7:0] {
    echo_reply   = 8'd0,
    echo_request = 8'd8
  } icmp_type_t;

  // ------------------------------------------------------------------------
  // Addresses
  // ------------------------------------------------------------------------
  localparam logic [47:0] BOARD_MAC       = 48'h00_11_22_33_44_55;
  localparam logic [31:0] BOARD_IP        = {8'd192, 8'd168, 8'd1, 8'd123};
  localparam logic [47:0] DEFAULT_DES_MAC = 48'hff_ff_ff_ff_ff_ff;  // Broadcast
  localparam logic [31:0] DEFAULT_DES_IP  = {8'd192, 8'd168, 8'd1, 8'd102};
  localparam logic [15:0] ETH_TYPE_IPV4   = 16'h0800;

  // Frame layout, in bytes
  localparam int PREAMBLE_BYTES    = 8;   // 7 x 55 then SFD
  localparam int HDR_BYTES         = 42;  // 14 Ethernet + 20 IP + 8 ICMP
  localparam int IP_ICMP_HDR_BYTES = 28;
  localparam int MIN_PAYLOAD       = 18;  // Keeps the MAC frame at 64 bytes
  localparam int FCS_BYTES         = 4;

  // Payload buffer and length fields
  localparam int FIFO_DEPTH   = 64;
  localparam int FIFO_LEVEL_W = 7;
  localparam int LEN_W        = 16;

endpackage

`default_nettype wire

// ==== src/crc32_d8.sv ====
/*
 * Byte-wide Ethernet CRC-32
 * Polynomial 04C11DB7 with each data byte fed in LSB first, which is the
 * mirror image of the reflected EDB88320 form; preset to all ones
 */
`timescale 1ns/10ps
`default_nettype none

module crc32_d8 (
  input  logic        clk,
  input  logic        resetn,
  input  logic        clr,
  input  logic        en,
  input  logic [7:0]  data,
  output logic [31:0] crc
);

  // Eight serial LFSR steps unrolled into one cycle
  function automatic logic [31:0] crc_next(input logic [31:0] c,
                                           input logic [7:0]  d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[31] ^ d[i];  // Wire order, bit 0 first
      r  = {r[30:0], 1'b0} ^ (fb ? 32'h04c1_1db7 : 32'h0000_0000);
    end
    return r;
  endfunction

  // ------------------------------------------------------------------------
  // Running remainder
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      crc <= 32'hffff_ffff;
    end else if (clr) begin
      crc <= 32'hffff_ffff;
    end else if (en) begin
      crc <= crc_next(crc, data);
    end
  end

endmodule

`default_nettype wire

// ==== src/byte_counter.sv ====
/*
 * Phase byte counter
 * Counts enabled cycles from zero after a load and flags the final count
 */
`timescale 1ns/10ps
`default_nettype none

module byte_counter
  import icmp_pkg::*;
(
  input  logic             clk,
  input  logic             resetn,
  input  logic             load,
  input  logic [LEN_W-1:0] limit,
  input  logic             en,
  output logic [LEN_W-1:0] value,
  output logic             last
);

  logic [LEN_W-1:0] limit_q;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      value   <= '0;
      limit_q <= '0;
    end else if (load) begin  // Load wins over the increment
      value   <= '0;
      limit_q <= limit;
    end else if (en) begin
      value <= value + 1'b1;
    end
  end

  assign last = (value == limit_q - 1'b1);

  // Sequencer must reload before running off the end of a phase
  a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
    (en && !load) |-> value < limit_q);

endmodule

`default_nettype wire

// ==== src/payload_fifo.sv ====
/*
 * Payload byte FIFO
 * 64-entry circular buffer, show-ahead read data and occupancy level
 */
`timescale 1ns/10ps
`default_nettype none

module payload_fifo
  import icmp_pkg::*;
(
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    wr_valid,
  input  logic [7:0]              wr_data,
  output logic                    wr_ready,
  input  logic                    pop,
  output logic [7:0]              rd_data,
  output logic [FIFO_LEVEL_W-1:0] level
);

  logic [7:0]              mem [FIFO_DEPTH];
  logic [FIFO_LEVEL_W-2:0] wr_ptr;  // Wraps naturally at 64
  logic [FIFO_LEVEL_W-2:0] rd_ptr;
  logic                    push;

  assign wr_ready = (level != FIFO_LEVEL_W'(FIFO_DEPTH));
  assign push     = wr_valid && wr_ready;
  assign rd_data  = mem[rd_ptr];  // Head byte always visible

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  // Sequencer only pops bytes it has counted in at accept
  a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
    pop |-> level != '0);

endmodule

`default_nettype wire

// ==== src/icmp_header_gen.sv ====
/*
 * Ethernet, IPv4 and ICMP header builder
 * Captures a send command, works out both checksums in a fixed
 * 8-step sequence and serves the 42 header bytes by index
 */
`timescale 1ns/10ps
`default_nettype none

module icmp_header_gen
  import icmp_pkg::*;
(
  input  logic             clk,
  input  logic             resetn,
  input  logic             load,
  input  icmp_type_t       cmd_type,
  input  logic [47:0]      cmd_des_mac,
  input  logic [31:0]      cmd_des_ip,
  input  logic [15:0]      cmd_icmp_id,
  input  logic [15:0]      cmd_icmp_seq,
  input  logic [LEN_W-1:0] cmd_len,
  input  logic [31:0]      cmd_data_sum,
  input  logic [5:0]       index,
  output logic [7:0]       hdr_byte,
  output logic             ready
);

  logic [47:0]              des_mac_q;
  logic [31:0]              des_ip_q;
  icmp_type_t               type_q;
  logic [15:0]              id_q;
  logic [15:0]              seq_q;
  logic [15:0]              total_len_q;
  logic [31:0]              data_sum_q;
  logic [15:0]              ip_ident;   // Bumped once per frame
  logic [15:0]              ip_cks;
  logic [15:0]              icmp_cks;
  logic [31:0]              sum;        // Shared by both checksums
  logic [3:0]               step;
  logic [8*HDR_BYTES-1:0]   hdr_vec;

  // Command capture, zero addresses fall back to the defaults
  always_ff @(posedge clk) begin
    if (load) begin
      des_mac_q   <= (cmd_des_mac != '0) ? cmd_des_mac : DEFAULT_DES_MAC;
      des_ip_q    <= (cmd_des_ip != '0) ? cmd_des_ip : DEFAULT_DES_IP;
      type_q      <= cmd_type;
      id_q        <= cmd_icmp_id;
      seq_q       <= cmd_icmp_seq;
      total_len_q <= cmd_len + LEN_W'(IP_ICMP_HDR_BYTES);
      data_sum_q  <= cmd_data_sum;
    end
  end

  // ------------------------------------------------------------------------
  // Checksum steps 1-4 for IP, 5-8 for ICMP
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      step     <= 4'd0;
      ready    <= 1'b0;
      ip_ident <= 16'd0;
    end else if (load) begin
      step     <= 4'd1;
      ready    <= 1'b0;
      ip_ident <= ip_ident + 16'd1;
    end else if (step != 4'd0) begin
      step <= step + 4'd1;
      if (step == 4'd8) begin
        step  <= 4'd0;
        ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (step)
      4'd1: sum <= 32'h4500 + total_len_q + ip_ident + 32'h4000 + 32'h8001 +
                   BOARD_IP[31:16] + BOARD_IP[15:0] + des_ip_q[31:16] + des_ip_q[15:0];
      4'd2, 4'd3, 4'd6, 4'd7: sum <= sum[31:16] + sum[15:0];  // Fold carries
      4'd4: ip_cks <= ~sum[15:0];
      4'd5: sum <= {type_q, 8'h00} + id_q + seq_q + data_sum_q;
      4'd8: icmp_cks <= ~sum[15:0];
      default: ;
    endcase
  end

  // Header image, byte 0 in the top bits
  assign hdr_vec = {des_mac_q, BOARD_MAC, ETH_TYPE_IPV4,
                    8'h45, 8'h00, total_len_q,           // Version/IHL, TOS
                    ip_ident, 16'h4000,                  // Don't fragment
                    8'h80, 8'h01, ip_cks,                // TTL, protocol ICMP
                    BOARD_IP, des_ip_q,
                    type_q, 8'h00, icmp_cks, id_q, seq_q};

  always_comb begin
    hdr_byte = 8'h00;
    if (index < HDR_BYTES) hdr_byte = hdr_vec[8*(HDR_BYTES-1-int'(index)) +: 8];
  end

endmodule

`default_nettype wire

// ==== src/icmp_tx_fsm.sv ====
/*
 * ICMP frame sequencer
 * Steps preamble, header, payload, pad and FCS phases and drives the
 * registered GMII byte stream
 */
`timescale 1ns/10ps
`default_nettype none

module icmp_tx_fsm
  import icmp_pkg::*;
(
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    cmd_valid,
  input  logic [LEN_W-1:0]        cmd_len,
  output logic                    cmd_ready,
  input  logic [FIFO_LEVEL_W-1:0] fifo_level,
  input  logic [7:0]              fifo_data,
  output logic                    pop,
  input  logic                    hdr_ready,
  input  logic [7:0]              hdr_byte,
  output logic                    hdr_load,
  output logic [5:0]              hdr_index,
  input  logic [LEN_W-1:0]        cnt_value,
  input  logic                    cnt_last,
  output logic                    cnt_load,
  output logic [LEN_W-1:0]        cnt_limit,
  output logic                    cnt_en,
  input  logic [31:0]             crc_value,
  output logic                    crc_en,
  output logic                    crc_clr,
  output logic [7:0]              crc_data,
  output logic                    gmii_tx_en,
  output logic [7:0]              gmii_txd,
  output logic                    tx_done
);

  tx_state_t        state;
  tx_state_t        next_state;
  logic [LEN_W-1:0] len_q;      // Payload length of the frame in flight
  logic [7:0]       tx_byte;
  logic [7:0]       fcs_src;
  logic             accept;
  logic             done_pend;  // Last FCS byte is on the wire

  // Invert and mirror one CRC byte for the wire
  function automatic logic [7:0] rev_inv(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = ~b[7 - i];
    end
    return r;
  endfunction

  // Zero length is never accepted
  assign cmd_ready = (state == st_idle) && !done_pend && (cmd_len != '0) &&
                     (LEN_W'(fifo_level) >= cmd_len);
  assign accept    = cmd_valid && cmd_ready;
  assign hdr_load  = accept;
  assign hdr_index = cnt_value[5:0];
  assign cnt_en    = state inside {st_preamble, st_header, st_payload, st_pad, st_fcs};
  assign crc_en    = state inside {st_header, st_payload, st_pad};
  assign pop       = (state == st_payload);
  assign crc_data  = tx_byte;
  assign crc_clr   = tx_done;

  // ------------------------------------------------------------------------
  // Phase sequencing and counter loads
  // ------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    cnt_load   = 1'b0;
    cnt_limit  = LEN_W'(FCS_BYTES);
    case (state)
      st_idle: begin
        if (accept) next_state = st_build;
      end
      st_build: begin
        if (hdr_ready) begin
          next_state = st_preamble;
          cnt_load   = 1'b1;
          cnt_limit  = LEN_W'(PREAMBLE_BYTES);
        end
      end
      st_preamble: begin
        if (cnt_last) begin
          next_state = st_header;
          cnt_load   = 1'b1;
          cnt_limit  = LEN_W'(HDR_BYTES);
        end
      end
      st_header: begin
        if (cnt_last) begin
          next_state = st_payload;
          cnt_load   = 1'b1;
          cnt_limit  = len_q;
        end
      end
      st_payload: begin
        if (cnt_last) begin
          cnt_load = 1'b1;
          if (len_q < LEN_W'(MIN_PAYLOAD)) begin
            next_state = st_pad;
            cnt_limit  = LEN_W'(MIN_PAYLOAD) - len_q;
          end else begin
            next_state = st_fcs;
          end
        end
      end
      st_pad: begin
        if (cnt_last) begin
          next_state = st_fcs;
          cnt_load   = 1'b1;
        end
      end
      st_fcs: begin
        if (cnt_last) next_state = st_idle;
      end
      default: next_state = st_idle;
    endcase
  end

  // FCS goes out high CRC byte first
  always_comb begin
    case (cnt_value[1:0])
      2'd0:    fcs_src = crc_value[31:24];
      2'd1:    fcs_src = crc_value[23:16];
      2'd2:    fcs_src = crc_value[15:8];
      default: fcs_src = crc_value[7:0];
    endcase
  end

  always_comb begin
    case (state)
      st_preamble: tx_byte = cnt_last ? 8'hd5 : 8'h55;  // SFD on the last one
      st_header:   tx_byte = hdr_byte;
      st_payload:  tx_byte = fifo_data;
      st_fcs:      tx_byte = rev_inv(fcs_src);
      default:     tx_byte = 8'h00;                     // Pad is zero fill
    endcase
  end

  // ------------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state      <= st_idle;
      gmii_tx_en <= 1'b0;
      gmii_txd   <= 8'h00;
      done_pend  <= 1'b0;
      tx_done    <= 1'b0;
    end else begin
      state      <= next_state;
      gmii_tx_en <= cnt_en;
      gmii_txd   <= tx_byte;
      done_pend  <= (state == st_fcs) && cnt_last;
      tx_done    <= done_pend;  // First cycle with gmii_tx_en low
    end
  end

  always_ff @(posedge clk) begin
    if (accept) len_q <= cmd_len;
  end

  a_idle_quiet: assert property (@(posedge clk) disable iff (!resetn)
    (state == st_idle && !done_pend) |-> !gmii_tx_en);

  a_len_fits: assert property (@(posedge clk) disable iff (!resetn)
    accept |-> cmd_len <= LEN_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== src/icmp_tx_top.sv ====
/*
 * ICMP frame transmitter, top level
 * Joins the frame sequencer, phase counter, header builder, CRC-32
 * generator and payload FIFO into one GMII byte source
 */
`timescale 1ns/10ps
`default_nettype none

module icmp_tx_top
  import icmp_pkg::*;
(
  input  logic             clk,
  input  logic             resetn,
  // Send command
  input  logic             cmd_valid,
  input  icmp_type_t       cmd_type,
  input  logic [47:0]      cmd_des_mac,
  input  logic [31:0]      cmd_des_ip,
  input  logic [15:0]      cmd_icmp_id,
  input  logic [15:0]      cmd_icmp_seq,
  input  logic [LEN_W-1:0] cmd_len,
  input  logic [31:0]      cmd_data_sum,
  output logic             cmd_ready,
  // Payload bytes
  input  logic             pay_valid,
  input  logic [7:0]       pay_data,
  output logic             pay_ready,
  // GMII transmit
  output logic             gmii_tx_en,
  output logic [7:0]       gmii_txd,
  output logic             tx_done
);

  logic                    cnt_load;
  logic [LEN_W-1:0]        cnt_limit;
  logic                    cnt_en;
  logic [LEN_W-1:0]        cnt_value;
  logic                    cnt_last;
  logic                    hdr_load;
  logic [5:0]              hdr_index;
  logic [7:0]              hdr_byte;
  logic                    hdr_ready;
  logic                    crc_en;
  logic                    crc_clr;
  logic [7:0]              crc_data;
  logic [31:0]             crc_value;
  logic                    pop;
  logic [7:0]              fifo_data;
  logic [FIFO_LEVEL_W-1:0] fifo_level;

  icmp_tx_fsm icmp_tx_fsm_inst (
    .clk        (clk),
    .resetn     (resetn),
    .cmd_valid  (cmd_valid),
    .cmd_len    (cmd_len),
    .cmd_ready  (cmd_ready),
    .fifo_level (fifo_level),
    .fifo_data  (fifo_data),
    .pop        (pop),
    .hdr_ready  (hdr_ready),
    .hdr_byte   (hdr_byte),
    .hdr_load   (hdr_load),
    .hdr_index  (hdr_index),
    .cnt_value  (cnt_value),
    .cnt_last   (cnt_last),
    .cnt_load   (cnt_load),
    .cnt_limit  (cnt_limit),
    .cnt_en     (cnt_en),
    .crc_value  (crc_value),
    .crc_en     (crc_en),
    .crc_clr    (crc_clr),
    .crc_data   (crc_data),
    .gmii_tx_en (gmii_tx_en),
    .gmii_txd   (gmii_txd),
    .tx_done    (tx_done)
  );

  byte_counter byte_counter_inst (
    .clk    (clk),
    .resetn (resetn),
    .load   (cnt_load),
    .limit  (cnt_limit),
    .en     (cnt_en),
    .value  (cnt_value),
    .last   (cnt_last)
  );

  icmp_header_gen icmp_header_gen_inst (
    .clk          (clk),
    .resetn       (resetn),
    .load         (hdr_load),
    .cmd_type     (cmd_type),
    .cmd_des_mac  (cmd_des_mac),
    .cmd_des_ip   (cmd_des_ip),
    .cmd_icmp_id  (cmd_icmp_id),
    .cmd_icmp_seq (cmd_icmp_seq),
    .cmd_len      (cmd_len),
    .cmd_data_sum (cmd_data_sum),
    .index        (hdr_index),
    .hdr_byte     (hdr_byte),
    .ready        (hdr_ready)
  );

  crc32_d8 crc32_d8_inst (
    .clk    (clk),
    .resetn (resetn),
    .clr    (crc_clr),
    .en     (crc_en),
    .data   (crc_data),
    .crc    (crc_value)
  );

  payload_fifo payload_fifo_inst (
    .clk      (clk),
    .resetn   (resetn),
    .wr_valid (pay_valid),
    .wr_data  (pay_data),
    .wr_ready (pay_ready),
    .pop      (pop),
    .rd_data  (fifo_data),
    .level    (fifo_level)
  );

endmodule

`default_nettype wire

// ==== bench/icmp_frame_model.svh ====
/*
 * ICMP frame reference model
 * Builds the expected GMII byte stream of one frame from a send command
 */
`ifndef ICMP_FRAME_MODEL_SVH
`define ICMP_FRAME_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// Big-endian 16-bit words, odd tail byte padded with zero
function automatic logic [31:0] word_sum(byte_q_t q, int first, int count);
  logic [31:0] s;
  s = 32'd0;
  for (int i = 0; i < count; i += 2) begin
    s += {q[first + i], (i + 1 < count) ? q[first + i + 1] : 8'h00};
  end
  return s;
endfunction

function automatic logic [15:0] fold_invert(logic [31:0] s);
  while (s[31:16] != 16'd0) s = s[31:16] + s[15:0];
  return ~s[15:0];
endfunction

// Reflected CRC-32 over the bytes from first to the end of the queue
function automatic logic [31:0] eth_crc(byte_q_t q, int first);
  logic [31:0] c;
  c = 32'hffff_ffff;
  for (int i = first; i < q.size(); i++) begin
    c ^= {24'h0, q[i]};
    for (int b = 0; b < 8; b++) c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
  end
  return ~c;
endfunction

function automatic void push_be(ref byte_q_t f, input logic [47:0] v, input int n);
  for (int i = n - 1; i >= 0; i--) f.push_back(v[8*i +: 8]);
endfunction

function automatic void build_frame(input logic [47:0] mac, input logic [31:0] ip,
                                    input icmp_type_t typ, input logic [15:0] id,
                                    input logic [15:0] seq, input logic [15:0] ident,
                                    input byte_q_t pay, output byte_q_t f);
  logic [47:0] dmac;
  logic [31:0] dip;
  logic [15:0] cks;
  logic [31:0] fcs;
  dmac = (mac == 48'd0) ? DEFAULT_DES_MAC : mac;
  dip  = (ip == 32'd0) ? DEFAULT_DES_IP : ip;
  f = {};
  push_be(f, 48'h5555_5555_5555, 6);
  push_be(f, 16'h55d5, 2);                    // Last preamble byte is the SFD
  push_be(f, dmac, 6);
  push_be(f, BOARD_MAC, 6);
  push_be(f, ETH_TYPE_IPV4, 2);
  push_be(f, 16'h4500, 2);
  push_be(f, 16'(pay.size() + IP_ICMP_HDR_BYTES), 2);
  push_be(f, ident, 2);
  push_be(f, 16'h4000, 2);
  push_be(f, 16'h8001, 2);                    // TTL 128, protocol ICMP
  push_be(f, 16'h0000, 2);
  push_be(f, BOARD_IP, 4);
  push_be(f, dip, 4);
  push_be(f, {typ, 8'h00}, 2);
  push_be(f, 16'h0000, 2);
  push_be(f, id, 2);
  push_be(f, seq, 2);
  foreach (pay[i]) f.push_back(pay[i]);
  cks = fold_invert(word_sum(f, 22, 20));     // IP header at offset 22
  f[32] = cks[15:8];
  f[33] = cks[7:0];
  cks = fold_invert(word_sum(f, 42, 8 + pay.size()));
  f[44] = cks[15:8];
  f[45] = cks[7:0];
  for (int i = pay.size(); i < MIN_PAYLOAD; i++) f.push_back(8'h00);
  fcs = eth_crc(f, PREAMBLE_BYTES);
  for (int i = 0; i < FCS_BYTES; i++) f.push_back(fcs[8*i +: 8]);
endfunction

`endif

// ==== bench/icmp_tx_tb.sv ====
/*
 * ICMP transmitter testbench
 * Directed frames checked byte for byte against the reference model
 */
`timescale 1ns/10ps
`default_nettype none

module icmp_tx_tb
  import icmp_pkg::*;
();

  localparam int NUM_TESTS   = 5;
  localparam int WATCHDOG_NS = NUM_TESTS * (150 + FIFO_DEPTH) * 4 + 4000;

  logic             clk;
  logic             resetn;
  logic             cmd_valid;
  icmp_type_t       cmd_type;
  logic [47:0]      cmd_des_mac;
  logic [31:0]      cmd_des_ip;
  logic [15:0]      cmd_icmp_id;
  logic [15:0]      cmd_icmp_seq;
  logic [LEN_W-1:0] cmd_len;
  logic [31:0]      cmd_data_sum;
  logic             cmd_ready;
  logic             pay_valid;
  logic [7:0]       pay_data;
  logic             pay_ready;
  logic             gmii_tx_en;
  logic [7:0]       gmii_txd;
  logic             tx_done;

`include "icmp_frame_model.svh"

  byte_q_t     rx_q;        // Bytes seen while gmii_tx_en is high
  int          en_runs;
  logic        en_last;
  int          next_ident;  // IP identification of the next frame

  icmp_tx_top icmp_tx_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (gmii_tx_en) begin
      rx_q.push_back(gmii_txd);
      if (!en_last) en_runs++;  // Counts enable bursts
    end
    en_last = gmii_tx_en;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog timeout, the tests did not finish in time");
  end

  // --------------------------------------------------------------------------
  // Failure and compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: expected %02h, actual %02h", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_type(input string name, input icmp_type_t exp, input icmp_type_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // --------------------------------------------------------------------------
  // Drivers entered 1 ns after a rising edge
  // --------------------------------------------------------------------------
  function automatic void random_payload(input int n, output byte_q_t q);
    q = {};
    repeat (n) q.push_back(8'($urandom()));
  endfunction

  task automatic write_bytes(input byte_q_t q, input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      pay_valid = 1'b1;
      pay_data  = q[i];
      do @(negedge clk); while (!pay_ready);
      @(posedge clk);
      #1;
    end
    pay_valid = 1'b0;
  endtask

  task automatic drive_cmd(input icmp_type_t typ, input logic [47:0] mac,
                           input logic [31:0] ip, input logic [15:0] id,
                           input logic [15:0] seq, input byte_q_t pay);
    rx_q         = {};
    en_runs      = 0;
    cmd_type     = typ;
    cmd_des_mac  = mac;
    cmd_des_ip   = ip;
    cmd_icmp_id  = id;
    cmd_icmp_seq = seq;
    cmd_len      = LEN_W'(pay.size());
    cmd_data_sum = word_sum(pay, 0, pay.size());  // Client side partial sum
    cmd_valid    = 1'b1;
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_ready) begin
      n++;
      if (n > 200) abort_run("cmd_ready never rose for the pending command");
      @(negedge clk);
    end
    @(posedge clk);
    #1 cmd_valid = 1'b0;
  endtask

  task automatic wait_frame(input string name, input byte_q_t exp);
    int   n;
    logic en_before;
    n = 0;
    @(negedge clk);
    while (!gmii_tx_en) begin
      n++;
      if (n > 50) abort_run("gmii_tx_en never rose after the command was taken");
      @(negedge clk);
    end
    check_count({name, " start latency"}, 10, n);
    en_before = 1'b1;
    n = 0;
    @(negedge clk);
    while (!tx_done) begin
      en_before = gmii_tx_en;
      n++;
      if (n > 300) abort_run("tx_done never pulsed at the end of the frame");
      @(negedge clk);
    end
    if (gmii_tx_en || !en_before) abort_run("tx_done did not follow the fall of gmii_tx_en");
    check_count({name, " enable length"}, exp.size(), rx_q.size());
    check_count({name, " enable bursts"}, 1, en_runs);
    foreach (exp[i]) check_byte($sformatf("%s byte %0d", name, i), exp[i], rx_q[i]);
    @(posedge clk);
    #1;
    check_count({name, " tx_done width"}, 0, int'(tx_done));  // Single-cycle pulse
  endtask

  task automatic send_frame(input string name, input icmp_type_t typ,
                            input logic [47:0] mac, input logic [31:0] ip,
                            input logic [15:0] id, input logic [15:0] seq,
                            input byte_q_t pay);
    byte_q_t exp;
    next_ident++;
    build_frame(mac, ip, typ, id, seq, 16'(next_ident), pay, exp);
    write_bytes(pay, 0, pay.size());
    drive_cmd(typ, mac, ip, id, seq, pay);
    wait_accept();
    wait_frame(name, exp);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_echo_reply();
    byte_q_t pay;
    random_payload(32, pay);
    send_frame("echo_reply", echo_reply, 48'h02_a0_b1_c2_d3_e4, 32'hc0a8_0114,
               16'h1234, 16'h0001, pay);
    check_type("echo_reply type", echo_reply, icmp_type_t'(rx_q[42]));
  endtask

  task automatic test_short_payload();
    byte_q_t pay;
    random_payload(5, pay);
    send_frame("short", echo_reply, 48'h02_00_00_00_00_07, 32'hc0a8_0107,
               16'h0042, 16'h0002, pay);
    check_count("short enable length", 72, rx_q.size());
    for (int i = 55; i < 68; i++) check_byte($sformatf("short pad %0d", i), 8'h00, rx_q[i]);
  endtask

  task automatic test_default_address();
    byte_q_t pay;
    random_payload(20, pay);
    send_frame("defaults", echo_request, 48'd0, 32'd0, 16'h00aa, 16'h0003, pay);
    for (int i = 8; i < 14; i++) check_byte("defaults dest MAC", 8'hff, rx_q[i]);
    check_byte("defaults dest IP 0", 8'd192, rx_q[38]);
    check_byte("defaults dest IP 1", 8'd168, rx_q[39]);
    check_byte("defaults dest IP 2", 8'd1, rx_q[40]);
    check_byte("defaults dest IP 3", 8'd102, rx_q[41]);
    check_type("defaults type", echo_request, icmp_type_t'(rx_q[42]));
  endtask

  task automatic test_fifo_wait();
    byte_q_t pay;
    byte_q_t exp;
    random_payload(24, pay);
    next_ident++;
    build_frame(48'h02_11_11_11_11_11, 32'hc0a8_0150, echo_request, 16'h0777, 16'h0004,
                16'(next_ident), pay, exp);
    write_bytes(pay, 0, 10);
    drive_cmd(echo_request, 48'h02_11_11_11_11_11, 32'hc0a8_0150, 16'h0777, 16'h0004, pay);
    repeat (20) begin
      @(negedge clk);
      check_count("fifo_wait cmd_ready", 0, int'(cmd_ready));
    end
    @(posedge clk);
    #1;
    write_bytes(pay, 10, 14);  // Level reaches cmd_len
    wait_accept();
    wait_frame("fifo_wait", exp);
  endtask

  task automatic test_back_to_back();
    byte_q_t pay;
    for (int f = 0; f < 3; f++) begin
      random_payload($urandom_range(64, 1), pay);
      send_frame($sformatf("frame %0d", f), echo_request, {16'h0200, $urandom()},
                 $urandom(), 16'($urandom()), 16'(f), pay);
      check_byte("frame ident hi", 8'(next_ident >> 8), rx_q[26]);
      check_byte("frame ident lo", 8'(next_ident), rx_q[27]);
    end
  endtask

  initial begin
    void'($urandom(32'h4b378d41));
    resetn       = 1'b0;
    cmd_valid    = 1'b0;
    cmd_type     = echo_reply;
    cmd_des_mac  = '0;
    cmd_des_ip   = '0;
    cmd_icmp_id  = '0;
    cmd_icmp_seq = '0;
    cmd_len      = '0;
    cmd_data_sum = '0;
    pay_valid    = 1'b0;
    pay_data     = '0;
    next_ident   = 0;
    en_runs      = 0;
    en_last      = 1'b0;
    repeat (8) @(posedge clk);
    #1 resetn = 1'b1;
    check_count("reset cmd_ready", 0, int'(cmd_ready));
    check_count("reset pay_ready", 1, int'(pay_ready));
    check_count("reset gmii_tx_en", 0, int'(gmii_tx_en));
    check_count("reset tx_done", 0, int'(tx_done));
    test_echo_reply();
    test_short_payload();
    test_default_address();
    test_fifo_wait();
    test_back_to_back();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+bench
src/icmp_pkg.sv
src/crc32_d8.sv
src/byte_counter.sv
src/payload_fifo.sv
src/icmp_header_gen.sv
src/icmp_tx_fsm.sv
src/icmp_tx_top.sv
bench/icmp_tx_tb.sv

// ==== Bender.yml ====
package:
  name: icmp_tx

sources:
  - src/icmp_pkg.sv
  - src/crc32_d8.sv
  - src/byte_counter.sv
  - src/payload_fifo.sv
  - src/icmp_header_gen.sv
  - src/icmp_tx_fsm.sv
  - src/icmp_tx_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/icmp_tx_tb.sv
